// File: include/pl_settings.svh
// bus, sample and reset widths, reset stretch length and ID constant
`ifndef PL_SETTINGS_SVH
`define PL_SETTINGS_SVH

// local bus
`define PL_DATA_WIDTH 32
`define PL_ADDR_WIDTH 10

// datapath
`define PL_SAMPLE_WIDTH 16

// reset conditioning
`define PL_RESET_STAGES 4
`define PL_RESETN_WIDTH 32

`define PL_ID_VALUE 32'h504c_0a01
`endif

// File: src/lb_pkg.sv
// local-bus word types and request/response structs
`default_nettype none
`include "pl_settings.svh"

package lb_pkg;

	typedef logic [`PL_ADDR_WIDTH-1:0] lb_addr_t;
	typedef logic [`PL_DATA_WIDTH-1:0] lb_data_t;

	// strobes are single-cycle, never both high
	typedef struct packed {
		logic     wr;
		logic     rd;
		lb_addr_t addr;
		lb_data_t wdata;
	} lb_req_t;

	typedef struct packed {
		logic     rvalid;
		lb_data_t rdata;
	} lb_rsp_t;

endpackage

`default_nettype wire

// File: src/dsp_pkg.sv
// sample, phase, amplitude and counter types plus the datapath register images
`default_nettype none
`include "pl_settings.svh"

package dsp_pkg;

	typedef logic signed [`PL_SAMPLE_WIDTH-1:0] sample_t;
	typedef logic [31:0] phase_t;
	// amplitude as a fraction of 65536
	typedef logic [15:0] amp_t;
	typedef logic [1:0] shift_t;
	typedef logic [31:0] count_t;
	// magnitude needs one more bit, |-32768| does not fit a sample
	typedef logic [`PL_SAMPLE_WIDTH:0] mag_t;

	typedef struct packed {
		logic   enable;
		phase_t inc;
		amp_t   amp;
	} chan_cfg_t;

	typedef struct packed {
		shift_t shift;
	} mix_cfg_t;

	typedef struct packed {
		count_t sat_count;
		mag_t   peak;
	} mix_stat_t;

endpackage

`default_nettype wire

// File: src/reset_shaper.sv
// reset stretcher driving the core reset and the wide active-low reset vectors
`timescale 1ns/1ns
`default_nettype none
`include "pl_settings.svh"

module reset_shaper (
	input  wire                         cfgclk,
	input  wire                         rst_n,
	output logic                        core_rst_n,
	output logic [`PL_RESETN_WIDTH-1:0] cfg_resetn,
	output logic [`PL_RESETN_WIDTH-1:0] dsp_resetn
);

	logic [`PL_RESET_STAGES-1:0] stretch;

	// ones shift in while rst_n stays high, msb releases the core
	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			stretch <= '0;
		end else begin
			stretch <= {stretch[`PL_RESET_STAGES-2:0], 1'b1};
		end
	end

	assign core_rst_n = stretch[`PL_RESET_STAGES-1];

	// wide copies follow the core reset one cycle later
	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			cfg_resetn <= '0;
			dsp_resetn <= '0;
		end else begin
			cfg_resetn <= {`PL_RESETN_WIDTH{core_rst_n}};
			dsp_resetn <= {`PL_RESETN_WIDTH{core_rst_n}};
		end
	end

endmodule

`default_nettype wire

// File: src/ctrl_regfile.sv
// control register bank on bus 1: ID, enables, channel A setup, saturation readback
`timescale 1ns/1ns
`default_nettype none
`include "pl_settings.svh"

module ctrl_regfile
	import lb_pkg::*, dsp_pkg::*;
(
	input  wire        cfgclk,
	input  wire        rst_n,
	input  lb_req_t    req,
	output lb_rsp_t    rsp,
	output chan_cfg_t  chan_a,
	output logic       enable_b,
	input  mix_stat_t  stat
);

	localparam lb_addr_t ADDR_ID     = 10'h000;
	localparam lb_addr_t ADDR_ENABLE = 10'h001;
	localparam lb_addr_t ADDR_INC_A  = 10'h002;
	localparam lb_addr_t ADDR_AMP_A  = 10'h003;
	localparam lb_addr_t ADDR_SAT    = 10'h004;

	logic [1:0] enables;
	phase_t     inc_a;
	amp_t       amp_a;
	lb_data_t   rd_data;

	// register writes
	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			enables <= '0;
			inc_a   <= '0;
			amp_a   <= '0;
		end else if (req.wr) begin
			case (req.addr)
				ADDR_ENABLE: enables <= req.wdata[1:0];
				ADDR_INC_A:  inc_a   <= req.wdata;
				ADDR_AMP_A:  amp_a   <= req.wdata[15:0];
				default: ;
			endcase
		end
	end

	// read mux, unmapped words read zero
	always_comb begin
		rd_data = '0;
		case (req.addr)
			ADDR_ID:     rd_data = `PL_ID_VALUE;
			ADDR_ENABLE: rd_data = {30'd0, enables};
			ADDR_INC_A:  rd_data = inc_a;
			ADDR_AMP_A:  rd_data = {16'd0, amp_a};
			ADDR_SAT:    rd_data = stat.sat_count;
			default:     rd_data = '0;
		endcase
	end

	// one-cycle read response
	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			rsp <= '0;
		end else begin
			rsp.rvalid <= req.rd;
			rsp.rdata  <= req.rd ? rd_data : '0;
		end
	end

	assign chan_a.enable = enables[0];
	assign chan_a.inc    = inc_a;
	assign chan_a.amp    = amp_a;
	// channel B enable is forwarded to the DSP bank
	assign enable_b      = enables[1];

endmodule

`default_nettype wire

// File: src/dsp_regfile.sv
// DSP register bank on bus 2: channel B setup, output shift, peak readback
`timescale 1ns/1ns
`default_nettype none

module dsp_regfile
	import lb_pkg::*, dsp_pkg::*;
(
	input  wire        cfgclk,
	input  wire        rst_n,
	input  lb_req_t    req,
	output lb_rsp_t    rsp,
	input  wire        enable_b,
	output chan_cfg_t  chan_b,
	output mix_cfg_t   mix,
	input  mix_stat_t  stat
);

	localparam lb_addr_t ADDR_INC_B = 10'h000;
	localparam lb_addr_t ADDR_AMP_B = 10'h001;
	localparam lb_addr_t ADDR_SHIFT = 10'h002;
	localparam lb_addr_t ADDR_PEAK  = 10'h003;

	phase_t   inc_b;
	amp_t     amp_b;
	shift_t   shift;
	lb_data_t rd_data;

	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			inc_b <= '0;
			amp_b <= '0;
			shift <= '0;
		end else if (req.wr) begin
			case (req.addr)
				ADDR_INC_B: inc_b <= req.wdata;
				ADDR_AMP_B: amp_b <= req.wdata[15:0];
				ADDR_SHIFT: shift <= req.wdata[1:0];
				default: ;
			endcase
		end
	end

	always_comb begin
		rd_data = '0;
		case (req.addr)
			ADDR_INC_B: rd_data = inc_b;
			ADDR_AMP_B: rd_data = {16'd0, amp_b};
			ADDR_SHIFT: rd_data = {30'd0, shift};
			// peak is zero-extended
			ADDR_PEAK:  rd_data = lb_data_t'(stat.peak);
			default:    rd_data = '0;
		endcase
	end

	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			rsp <= '0;
		end else begin
			rsp.rvalid <= req.rd;
			rsp.rdata  <= req.rd ? rd_data : '0;
		end
	end

	assign chan_b.enable = enable_b;
	assign chan_b.inc    = inc_b;
	assign chan_b.amp    = amp_b;
	assign mix.shift     = shift;

endmodule

`default_nettype wire

// File: src/tone_channel.sv
// triangle tone channel: phase accumulator, triangle fold and amplitude scaling
`timescale 1ns/1ns
`default_nettype none

module tone_channel
	import dsp_pkg::*;
(
	input  wire        cfgclk,
	input  wire        core_rst_n,
	input  chan_cfg_t  cfg,
	output sample_t    tone
);

	phase_t             phase;
	logic signed [16:0] tri_w;
	logic signed [16:0] amp_w;
	logic signed [33:0] prod;

	// accumulator, a disabled channel parks at phase zero
	always_ff @(posedge cfgclk) begin
		if (!core_rst_n) begin
			phase <= '0;
		end else if (cfg.enable) begin
			phase <= phase + cfg.inc;
		end else begin
			phase <= '0;
		end
	end

	// fold top 16 phase bits into a triangle
	// rising half spans -32768..32766, falling half 32767..-32767
	always_comb begin
		if (!phase[31]) begin
			tri_w = $signed({1'b0, phase[30:16], 1'b0}) - 17'sd32768;
		end else begin
			tri_w = 17'sd32767 - $signed({1'b0, phase[30:16], 1'b0});
		end
		amp_w = $signed({1'b0, cfg.amp});
		prod  = tri_w * amp_w;
	end

	// product >>> 16 always fits a sample, so bits 31:16 are the result
	// output held at zero while the channel is off
	always_ff @(posedge cfgclk) begin
		if (!core_rst_n) begin
			tone <= '0;
		end else if (cfg.enable) begin
			tone <= prod[31:16];
		end else begin
			tone <= '0;
		end
	end

endmodule

`default_nettype wire

// File: src/mix_combiner.sv
// two-channel combiner: sum, shift, saturate, saturation counter and peak magnitude
`timescale 1ns/1ns
`default_nettype none

module mix_combiner
	import dsp_pkg::*;
(
	input  wire        cfgclk,
	input  wire        core_rst_n,
	input  sample_t    tone_a,
	input  sample_t    tone_b,
	input  mix_cfg_t   cfg,
	output sample_t    sample_out,
	output mix_stat_t  stat
);

	logic signed [16:0] sum_w;
	logic signed [16:0] shifted_w;
	logic signed [16:0] clip_w;
	logic               sat_w;
	mag_t               mag_w;

	always_comb begin
		sum_w     = tone_a + tone_b;
		shifted_w = sum_w >>> cfg.shift;
		// clamp to the 16-bit signed range
		if (shifted_w > 17'sd32767) begin
			clip_w = 17'sd32767;
			sat_w  = 1'b1;
		end else if (shifted_w < -17'sd32768) begin
			clip_w = -17'sd32768;
			sat_w  = 1'b1;
		end else begin
			clip_w = shifted_w;
			sat_w  = 1'b0;
		end
		// magnitude of the sample about to be registered
		mag_w = (clip_w < 0) ? mag_t'(-clip_w) : mag_t'(clip_w);
	end

	always_ff @(posedge cfgclk) begin
		if (!core_rst_n) begin
			sample_out <= '0;
		end else begin
			sample_out <= clip_w[15:0];
		end
	end

	// status tracks the same cycle as sample_out
	always_ff @(posedge cfgclk) begin
		if (!core_rst_n) begin
			stat <= '0;
		end else begin
			if (sat_w) begin
				stat.sat_count <= stat.sat_count + 1'b1;
			end
			if (mag_w > stat.peak) begin
				stat.peak <= mag_w;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/pl_top.sv
// top level: register banks, reset shaper, two tone channels and the combiner
`timescale 1ns/1ns
`default_nettype none
`include "pl_settings.svh"

module pl_top
	import lb_pkg::*, dsp_pkg::*;
(
	input  wire                          cfgclk,
	input  wire                          rst_n,
	input  lb_req_t                      lb1_req,
	input  lb_req_t                      lb2_req,
	output lb_rsp_t                      lb1_rsp,
	output lb_rsp_t                      lb2_rsp,
	output sample_t                      sample_out,
	output logic [`PL_RESETN_WIDTH-1:0]  cfg_resetn,
	output logic [`PL_RESETN_WIDTH-1:0]  dsp_resetn
);

	logic      core_rst_n;
	logic      enable_b;
	chan_cfg_t chan_a;
	chan_cfg_t chan_b;
	mix_cfg_t  mix_cfg;
	mix_stat_t stat;
	sample_t   tone_a_w;
	sample_t   tone_b_w;

	reset_shaper u_reset_shaper (
		.cfgclk     (cfgclk),
		.rst_n      (rst_n),
		.core_rst_n (core_rst_n),
		.cfg_resetn (cfg_resetn),
		.dsp_resetn (dsp_resetn)
	);

	// bus 1 carries channel A and the B enable
	ctrl_regfile u_ctrl_regs (
		.cfgclk   (cfgclk),
		.rst_n    (rst_n),
		.req      (lb1_req),
		.rsp      (lb1_rsp),
		.chan_a   (chan_a),
		.enable_b (enable_b),
		.stat     (stat)
	);

	dsp_regfile u_dsp_regs (
		.cfgclk   (cfgclk),
		.rst_n    (rst_n),
		.req      (lb2_req),
		.rsp      (lb2_rsp),
		.enable_b (enable_b),
		.chan_b   (chan_b),
		.mix      (mix_cfg),
		.stat     (stat)
	);

	tone_channel tone_a (
		.cfgclk     (cfgclk),
		.core_rst_n (core_rst_n),
		.cfg        (chan_a),
		.tone       (tone_a_w)
	);

	tone_channel tone_b (
		.cfgclk     (cfgclk),
		.core_rst_n (core_rst_n),
		.cfg        (chan_b),
		.tone       (tone_b_w)
	);

	mix_combiner u_mix (
		.cfgclk     (cfgclk),
		.core_rst_n (core_rst_n),
		.tone_a     (tone_a_w),
		.tone_b     (tone_b_w),
		.cfg        (mix_cfg),
		.sample_out (sample_out),
		.stat       (stat)
	);

endmodule

`default_nettype wire

// File: dv/pl_assertions.sv
// bound checks on bus strobes, read response timing and wide reset outputs
`timescale 1ns/1ns
`default_nettype none
`include "pl_settings.svh"

module pl_assertions
	import lb_pkg::*;
(
	input wire                         cfgclk,
	input wire                         rst_n,
	input wire                         core_rst_n,
	input lb_req_t                     lb1_req,
	input lb_req_t                     lb2_req,
	input lb_rsp_t                     lb1_rsp,
	input lb_rsp_t                     lb2_rsp,
	input wire [`PL_RESETN_WIDTH-1:0]  cfg_resetn,
	input wire [`PL_RESETN_WIDTH-1:0]  dsp_resetn
);

	a_lb1_excl: assert property (@(posedge cfgclk) disable iff (!rst_n)
		!(lb1_req.wr && lb1_req.rd)) else $error("bus 1 read and write together");
	a_lb2_excl: assert property (@(posedge cfgclk) disable iff (!rst_n)
		!(lb2_req.wr && lb2_req.rd)) else $error("bus 2 read and write together");

	// rvalid is the read strobe delayed by one cycle
	a_lb1_rvalid: assert property (@(posedge cfgclk) disable iff (!rst_n)
		lb1_rsp.rvalid == $past(lb1_req.rd)) else $error("bus 1 rvalid timing");
	a_lb2_rvalid: assert property (@(posedge cfgclk) disable iff (!rst_n)
		lb2_rsp.rvalid == $past(lb2_req.rd)) else $error("bus 2 rvalid timing");

	// wide resets are whole copies of the core reset one cycle later
	a_cfg_rst: assert property (@(posedge cfgclk) disable iff (!rst_n)
		$past(core_rst_n) ? (cfg_resetn == '1) : (cfg_resetn == '0))
		else $error("cfg_resetn does not follow the core reset");
	a_dsp_rst: assert property (@(posedge cfgclk) disable iff (!rst_n)
		$past(core_rst_n) ? (dsp_resetn == '1) : (dsp_resetn == '0))
		else $error("dsp_resetn does not follow the core reset");

endmodule

`default_nettype wire

// File: dv/pl_checker.sv
// sample checker: shadow registers, reference model of the tone pipeline, per-cycle compare
`timescale 1ns/1ns
`default_nettype none
`include "pl_settings.svh"

module pl_checker
	import lb_pkg::*, dsp_pkg::*;
(
	input  wire                         cfgclk,
	input  wire                         rst_n,
	input  lb_req_t                     lb1_req,
	input  lb_req_t                     lb2_req,
	input  sample_t                     sample_out,
	input  wire [`PL_RESETN_WIDTH-1:0]  cfg_resetn,
	output int                          mismatches,
	output count_t                      sat_model,
	output mag_t                        peak_model
);

	logic [1:0]  en;
	logic [31:0] inc_a;
	logic [31:0] inc_b;
	logic [15:0] amp_a;
	logic [15:0] amp_b;
	logic [1:0]  shift;
	logic [31:0] ph_a;
	logic [31:0] ph_b;
	int          tone_a_m;
	int          tone_b_m;
	int          exp_sample;
	int          raw;
	int          mixed;
	int          mag;

	// triangle from the top phase bits, scaled by amp/65536
	function automatic int tone_ref(input logic [31:0] ph, input logic [15:0] amp);
		int     u;
		int     t;
		longint p;
		u = int'(ph[31:16]);
		if (u < 32768) t = 2 * u - 32768;
		else t = 32767 - 2 * (u - 32768);
		p = longint'(t) * longint'(int'(amp));
		return int'(p >>> 16);
	endfunction

	function automatic int clip16(input int v);
		if (v > 32767) return 32767;
		if (v < -32768) return -32768;
		return v;
	endfunction

	always @(posedge cfgclk) begin
		if (!rst_n) begin
			en <= '0;
			inc_a <= '0;
			inc_b <= '0;
			amp_a <= '0;
			amp_b <= '0;
			shift <= '0;
			ph_a <= '0;
			ph_b <= '0;
			tone_a_m <= 0;
			tone_b_m <= 0;
			exp_sample <= 0;
			sat_model <= '0;
			peak_model <= '0;
		end else begin
			if (lb1_req.wr) begin
				case (lb1_req.addr)
					10'h001: en <= lb1_req.wdata[1:0];
					10'h002: inc_a <= lb1_req.wdata;
					10'h003: amp_a <= lb1_req.wdata[15:0];
					default: ;
				endcase
			end
			if (lb2_req.wr) begin
				case (lb2_req.addr)
					10'h000: inc_b <= lb2_req.wdata;
					10'h001: amp_b <= lb2_req.wdata[15:0];
					10'h002: shift <= lb2_req.wdata[1:0];
					default: ;
				endcase
			end
			ph_a <= en[0] ? ph_a + inc_a : 32'h0;
			ph_b <= en[1] ? ph_b + inc_b : 32'h0;
			tone_a_m <= en[0] ? tone_ref(ph_a, amp_a) : 0;
			tone_b_m <= en[1] ? tone_ref(ph_b, amp_b) : 0;
			raw = (tone_a_m + tone_b_m) >>> shift;
			mixed = clip16(raw);
			mag = (mixed < 0) ? -mixed : mixed;
			exp_sample <= mixed;
			if (mixed != raw) sat_model <= sat_model + 32'd1;
			if (mag > int'(peak_model)) peak_model <= mag_t'(mag);
		end
	end

	// compare mid-cycle once the wide resets are released
	initial mismatches = 0;
	always @(negedge cfgclk) begin
		if (cfg_resetn === '1 && int'(sample_out) != exp_sample) begin
			$display("MISMATCH sample_out: got 0x%04h expected 0x%04h at %0t",
				sample_out, exp_sample[15:0], $time);
			mismatches <= mismatches + 1;
		end
	end

endmodule

`default_nettype wire

// File: dv/pl_tb.sv
// testbench top with clock, reset, seeding, bus read and write tasks, test sequence and report
`timescale 1ns/1ns
`default_nettype none
`include "pl_settings.svh"

module pl_tb
	import lb_pkg::*, dsp_pkg::*;
;

	localparam int READ_TIMEOUT  = 16;
	localparam int RESET_TIMEOUT = 20;

	logic                        cfgclk;
	logic                        rst_n;
	lb_req_t                     lb1_req;
	lb_req_t                     lb2_req;
	lb_rsp_t                     lb1_rsp;
	lb_rsp_t                     lb2_rsp;
	sample_t                     sample_out;
	logic [`PL_RESETN_WIDTH-1:0] cfg_resetn;
	logic [`PL_RESETN_WIDTH-1:0] dsp_resetn;
	int                          errors;
	int                          mismatches;
	count_t                      sat_model;
	mag_t                        peak_model;

	pl_top dut (
		.cfgclk     (cfgclk),
		.rst_n      (rst_n),
		.lb1_req    (lb1_req),
		.lb2_req    (lb2_req),
		.lb1_rsp    (lb1_rsp),
		.lb2_rsp    (lb2_rsp),
		.sample_out (sample_out),
		.cfg_resetn (cfg_resetn),
		.dsp_resetn (dsp_resetn)
	);

	pl_checker u_checker (
		.cfgclk     (cfgclk),
		.rst_n      (rst_n),
		.lb1_req    (lb1_req),
		.lb2_req    (lb2_req),
		.sample_out (sample_out),
		.cfg_resetn (cfg_resetn),
		.mismatches (mismatches),
		.sat_model  (sat_model),
		.peak_model (peak_model)
	);

	bind pl_top pl_assertions u_assert (
		.cfgclk     (cfgclk),
		.rst_n      (rst_n),
		.core_rst_n (core_rst_n),
		.lb1_req    (lb1_req),
		.lb2_req    (lb2_req),
		.lb1_rsp    (lb1_rsp),
		.lb2_rsp    (lb2_rsp),
		.cfg_resetn (cfg_resetn),
		.dsp_resetn (dsp_resetn)
	);

	// 4 ns period
	always #2 cfgclk = ~cfgclk;

	task automatic run_cycles(input int n);
		repeat (n) @(posedge cfgclk);
		#1;
	endtask

	task automatic bus_write(input int bus, input lb_addr_t addr, input lb_data_t data);
		lb_req_t req;
		req       = '0;
		req.wr    = 1'b1;
		req.addr  = addr;
		req.wdata = data;
		if (bus == 1) lb1_req = req;
		else lb2_req = req;
		@(posedge cfgclk);
		#1;
		lb1_req = '0;
		lb2_req = '0;
	endtask

	task automatic bus_read(input int bus, input lb_addr_t addr, input lb_data_t expected,
			input string name);
		lb_req_t req;
		lb_rsp_t rsp;
		int      waited;
		req      = '0;
		req.rd   = 1'b1;
		req.addr = addr;
		if (bus == 1) lb1_req = req;
		else lb2_req = req;
		@(posedge cfgclk);
		#1;
		lb1_req = '0;
		lb2_req = '0;
		waited  = 0;
		rsp     = (bus == 1) ? lb1_rsp : lb2_rsp;
		while (!rsp.rvalid && waited < READ_TIMEOUT) begin
			@(posedge cfgclk);
			#1;
			waited++;
			rsp = (bus == 1) ? lb1_rsp : lb2_rsp;
		end
		if (!rsp.rvalid) begin
			$display("read on bus %0d at address 0x%03h got no rvalid in time", bus, addr);
			errors++;
		end else if (waited != 0) begin
			$display("read on bus %0d at address 0x%03h answered %0d cycles late",
				bus, addr, waited);
			errors++;
		end else if (rsp.rdata !== expected) begin
			$display("MISMATCH %s: got 0x%08h expected 0x%08h", name, rsp.rdata, expected);
			errors++;
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, expected);
			errors++;
		end
	endtask

	initial begin
		lb_data_t v_en;
		lb_data_t v_inc_a;
		lb_data_t v_amp_a;
		lb_data_t v_inc_b;
		lb_data_t v_amp_b;
		lb_data_t v_shift;
		lb_data_t v_inc;
		int       cycles;

		cfgclk  = 1'b0;
		rst_n   = 1'b0;
		lb1_req = '0;
		lb2_req = '0;
		errors  = 0;
		void'($urandom(21745));

		// outputs stay quiet through the 8-cycle reset
		run_cycles(7);
		check_value("cfg_resetn", cfg_resetn, 32'h0);
		check_value("dsp_resetn", dsp_resetn, 32'h0);
		check_value("sample_out", 32'(sample_out), 32'h0);
		run_cycles(1);
		rst_n  = 1'b1;
		cycles = 0;
		while (cfg_resetn !== '1 && cycles < RESET_TIMEOUT) begin
			@(posedge cfgclk);
			#1;
			cycles++;
		end
		if (cfg_resetn !== '1) begin
			$display("cfg_resetn never released after rst_n rose");
			errors++;
		end else begin
			check_value("reset release cycles", cycles, `PL_RESET_STAGES + 1);
		end
		check_value("dsp_resetn", dsp_resetn, 32'hffff_ffff);
		bus_read(1, 10'h000, `PL_ID_VALUE, "lb1_rsp.rdata id");

		// readback of every writable register
		v_en    = $urandom;
		v_inc_a = $urandom;
		v_amp_a = $urandom;
		v_inc_b = $urandom;
		v_amp_b = $urandom;
		v_shift = $urandom;
		bus_write(1, 10'h001, v_en);
		bus_write(1, 10'h002, v_inc_a);
		bus_write(1, 10'h003, v_amp_a);
		bus_write(2, 10'h000, v_inc_b);
		bus_write(2, 10'h001, v_amp_b);
		bus_write(2, 10'h002, v_shift);
		bus_read(1, 10'h001, v_en & 32'h3, "lb1_rsp.rdata enables");
		bus_read(1, 10'h002, v_inc_a, "lb1_rsp.rdata inc_a");
		bus_read(1, 10'h003, v_amp_a & 32'hffff, "lb1_rsp.rdata amp_a");
		bus_read(2, 10'h000, v_inc_b, "lb2_rsp.rdata inc_b");
		bus_read(2, 10'h001, v_amp_b & 32'hffff, "lb2_rsp.rdata amp_b");
		bus_read(2, 10'h002, v_shift & 32'h3, "lb2_rsp.rdata shift");
		bus_read(1, 10'h005, 32'h0, "lb1_rsp.rdata unmapped");
		bus_read(1, 10'h3ff, 32'h0, "lb1_rsp.rdata unmapped");
		bus_read(2, 10'h004, 32'h0, "lb2_rsp.rdata unmapped");
		bus_read(2, 10'h200, 32'h0, "lb2_rsp.rdata unmapped");
		bus_write(1, 10'h001, 32'h0);

		// channel A alone
		bus_write(2, 10'h002, 32'h0);
		bus_write(1, 10'h002, $urandom);
		bus_write(1, 10'h003, $urandom);
		bus_write(1, 10'h001, 32'h1);
		run_cycles(300);
		bus_write(1, 10'h001, 32'h0);
		// two pipeline stages to drain
		run_cycles(3);
		check_value("sample_out", 32'(sample_out), 32'h0);

		// both channels with a random shift
		bus_write(1, 10'h002, $urandom);
		bus_write(1, 10'h003, $urandom);
		bus_write(2, 10'h000, $urandom);
		bus_write(2, 10'h001, $urandom);
		bus_write(2, 10'h002, $urandom % 4);
		bus_write(1, 10'h001, 32'h3);
		run_cycles(400);
		bus_write(1, 10'h001, 32'h0);
		run_cycles(3);

		// identical full-scale tones with no shift must clip
		v_inc = 32'h0100_0000 | ($urandom & 32'h00ff_ffff);
		bus_write(1, 10'h002, v_inc);
		bus_write(2, 10'h000, v_inc);
		bus_write(1, 10'h003, 32'hffff);
		bus_write(2, 10'h001, 32'hffff);
		bus_write(2, 10'h002, 32'h0);
		bus_write(1, 10'h001, 32'h3);
		run_cycles(600);
		bus_write(1, 10'h001, 32'h0);
		run_cycles(4);
		if (sat_model == 0) begin
			$display("full-scale tones never reached saturation");
			errors++;
		end
		bus_read(1, 10'h004, sat_model, "lb1_rsp.rdata sat_count");
		bus_read(2, 10'h003, 32'(peak_model), "lb2_rsp.rdata peak");
		run_cycles(2);

		$display("errors: bus and port checks %0d, sample compares %0d", errors, mismatches);
		if (errors == 0 && mismatches == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
src/lb_pkg.sv
src/dsp_pkg.sv
src/reset_shaper.sv
src/ctrl_regfile.sv
src/dsp_regfile.sv
src/tone_channel.sv
src/mix_combiner.sv
src/pl_top.sv
dv/pl_assertions.sv
dv/pl_checker.sv
dv/pl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator and run; success only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module pl_tb -o pl_sim \
	&& ./obj_dir/pl_sim | tee /dev/stderr | grep -qx "PASS: all tests" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
